// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_multiply_mem_uart
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  OBJ_DIR=$(OBJ_DIR) VFLAGS=\"$(VFLAGS)\""

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_multiply_mem_uart.sv ====
`timescale 1ns/1ps

module tb_multiply_mem_uart import mul_pkg::*; ();

   localparam int DATA_WIDTH    = 32;
   localparam int ADDR_WIDTH    = 4;
   localparam int SAMPLE        = 8;
   localparam int HALF          = DATA_WIDTH / 2;
   localparam int NBYTES        = DATA_WIDTH / 8;
   localparam int NROWS         = 8;
   localparam int PASS_CYCLES   = 8 * (HALF + 4);
   localparam int SETTLE_CYCLES = 2 * PASS_CYCLES + 10 * SAMPLE;
   localparam int REPLY_TIMEOUT = 40 * SAMPLE;
   localparam int IDLE_WINDOW   = 40 * SAMPLE;

   typedef logic [DATA_WIDTH-1:0] word_t;
   typedef logic [ADDR_WIDTH-1:0] addr_t;

   typedef struct packed {
      logic [2:0] slot;
      word_t      operand;
      word_t      product;
   } row_t;

   logic i_clk;
   logic i_nrst;
   logic i_rx;
   logic o_tx;

   row_t rows [NROWS];
   int   errors;
   int   tests_run;
   int   tests_failed;

   multiply_mem_uart #(
      .DATA_WIDTH (DATA_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH),
      .SAMPLE     (SAMPLE)
   ) multiply_mem_uart_i (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_rx   (i_rx),
      .o_tx   (o_tx)
   );

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   // Low half times high half, unsigned.
   function automatic word_t half_product(input word_t w);
      word_t lo;
      word_t hi;
      lo = word_t'(w[HALF-1:0]);
      hi = word_t'(w[DATA_WIDTH-1:HALF]);
      return lo * hi;
   endfunction

   task automatic check_equal(input string what, input word_t got, input word_t expected);
      if (got !== expected) begin
         $display("Fail at %0t: %s is %h, expected %h", $time, what, got, expected);
         errors++;
      end
   endtask

   task automatic end_test(input string name, input int errors_at_start);
      tests_run++;
      if (errors == errors_at_start) begin
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed", name);
      end
   endtask

   task automatic send_byte(input byte_t b);
      logic [9:0] frame;
      int         i;
      frame = {1'b1, b, 1'b0}; // Stop, data LSB first, start.
      for (i = 0; i < 10; i++) begin
         @(posedge i_clk);
         i_rx <= frame[i];
         repeat (SAMPLE - 1) @(posedge i_clk);
      end
   endtask

   task automatic receive_byte(output byte_t b, output logic ok);
      int waited;
      int i;
      b      = '0;
      ok     = 1'b0;
      waited = 0;
      @(negedge i_clk);
      while (o_tx !== 1'b0 && waited < REPLY_TIMEOUT) begin
         @(negedge i_clk);
         waited++;
      end
      if (o_tx !== 1'b0) begin
         $display("Error at %0t: no reply from UART", $time);
         errors++;
         return;
      end
      repeat (SAMPLE / 2) @(negedge i_clk); // Middle of the start bit.
      for (i = 0; i < 8; i++) begin
         repeat (SAMPLE) @(negedge i_clk);
         b[i] = o_tx;
      end
      repeat (SAMPLE) @(negedge i_clk);
      ok = (o_tx === 1'b1);
      if (!ok) begin
         $display("Error at %0t: UART stop bit is missing", $time);
         errors++;
      end
   endtask

   task automatic write_word(input addr_t addr, input word_t w);
      int i;
      send_byte(CMD_WRITE);
      send_byte(byte_t'(addr));
      for (i = 0; i < NBYTES; i++)
         send_byte(w[8*i +: 8]);
   endtask

   task automatic read_word(input addr_t addr, output word_t w);
      byte_t b;
      logic  ok;
      int    i;
      w = 'x;
      send_byte(CMD_READ);
      send_byte(byte_t'(addr));
      for (i = 0; i < NBYTES; i++) begin
         receive_byte(b, ok);
         if (!ok)
            return;
         w[8*i +: 8] = b;
      end
   endtask

   initial begin
      word_t got;
      word_t new_operand;
      int    idle_low;
      int    mark;
      int    i;

      i_nrst       = 1'b0;
      i_rx         = 1'b1;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      void'($urandom(32'hf004_3b52));

      rows[0] = '{slot: 3'd0, operand: 32'h0000_0000, product: '0};
      rows[1] = '{slot: 3'd1, operand: 32'hffff_ffff, product: '0};
      rows[2] = '{slot: 3'd2, operand: 32'h1234_0001, product: '0}; // 1 x N.
      rows[3] = '{slot: 3'd3, operand: 32'h0001_beef, product: '0};
      for (i = 4; i < NROWS; i++)
         rows[i] = '{slot: 3'(i), operand: $urandom(), product: '0};
      for (i = 0; i < NROWS; i++)
         rows[i].product = half_product(rows[i].operand);

      repeat (5) @(posedge i_clk);
      i_nrst <= 1'b1;

      // Line must stay idle with no start bit.
      mark     = errors;
      idle_low = 0;
      for (i = 0; i < IDLE_WINDOW; i++) begin
         @(negedge i_clk);
         if (o_tx !== 1'b1)
            idle_low++;
      end
      check_equal("o_tx low cycles after reset", word_t'(idle_low), '0);
      end_test("reset idle", mark);

      for (i = 0; i < NROWS; i++)
         write_word(addr_t'(rows[i].slot), rows[i].operand);
      repeat (SETTLE_CYCLES) @(posedge i_clk);

      for (i = 0; i < NROWS; i++) begin
         mark = errors;
         read_word(addr_t'(rows[i].slot), got);
         check_equal($sformatf("operand slot %0d", rows[i].slot), got, rows[i].operand);
         read_word(addr_t'({1'b1, rows[i].slot}), got);
         check_equal($sformatf("product slot %0d", rows[i].slot + 8), got, rows[i].product);
         end_test($sformatf("row %0d", i), mark);
      end

      mark        = errors;
      new_operand = $urandom();
      write_word(addr_t'(rows[3].slot), new_operand);
      repeat (SETTLE_CYCLES) @(posedge i_clk);
      read_word(addr_t'(rows[3].slot), got);
      check_equal("rewritten operand", got, new_operand);
      read_word(addr_t'({1'b1, rows[3].slot}), got);
      check_equal("product after rewrite", got, half_product(new_operand));
      end_test("overwrite", mark);

      // Stray byte in idle is dropped.
      mark = errors;
      send_byte(8'ha5);
      read_word(addr_t'(rows[5].slot), got);
      check_equal("read after unknown byte", got, rows[5].operand);
      end_test("unknown byte", mark);

      $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== build.f ====
source/mul_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/host_cmd.sv
source/word_mem.sv
source/mem_uart.sv
source/shift_add_multiplier.sv
source/multiply_mem_uart.sv
bench/tb_multiply_mem_uart.sv

// ==== source/host_cmd.sv ====
`timescale 1ns/1ps

module host_cmd import mul_pkg::*; #(
   parameter int DATA_WIDTH = 128,
   parameter int ADDR_WIDTH = 8
) (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  byte_t                 i_rx_byte,
   input  logic                  i_rx_valid,
   output byte_t                 o_tx_byte,
   output logic                  o_tx_valid,
   input  logic                  i_tx_accept,
   output logic                  o_req,
   output logic                  o_req_write,
   output logic [ADDR_WIDTH-1:0] o_req_addr,
   output logic [DATA_WIDTH-1:0] o_req_data,
   input  logic                  i_grant,
   input  logic [DATA_WIDTH-1:0] i_rd_data
);

   typedef logic [DATA_WIDTH-1:0] word_t;
   typedef logic [ADDR_WIDTH-1:0] addr_t;

   localparam int NBYTES = DATA_WIDTH / 8;
   localparam int CNT_W  = $clog2(NBYTES);

   host_state_e      state;
   logic             is_write;
   logic [CNT_W-1:0] byte_cnt;
   addr_t            addr_q;
   word_t            word_q; // Write data in, read data out.

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state      <= IDLE;
         is_write   <= 1'b0;
         byte_cnt   <= '0;
         o_req      <= 1'b0;
         o_tx_valid <= 1'b0;
      end else begin
         case (state)
            IDLE: if (i_rx_valid) begin
               if (i_rx_byte == CMD_WRITE || i_rx_byte == CMD_READ) begin
                  is_write <= (i_rx_byte == CMD_WRITE);
                  state    <= ADDR;
               end
            end
            ADDR: if (i_rx_valid) begin
               byte_cnt <= '0;
               if (is_write) begin
                  state <= DATA_IN;
               end else begin
                  o_req <= 1'b1;
                  state <= MEM_WAIT;
               end
            end
            DATA_IN: if (i_rx_valid) begin
               byte_cnt <= byte_cnt + 1'b1;
               if (byte_cnt == CNT_W'(NBYTES - 1)) begin
                  o_req <= 1'b1;
                  state <= MEM_WAIT;
               end
            end
            MEM_WAIT: if (i_grant) begin
               o_req    <= 1'b0;
               byte_cnt <= '0;
               if (is_write) begin
                  state <= IDLE;
               end else begin
                  o_tx_valid <= 1'b1;
                  state      <= DATA_OUT;
               end
            end
            DATA_OUT: if (i_tx_accept) begin
               byte_cnt <= byte_cnt + 1'b1;
               if (byte_cnt == CNT_W'(NBYTES - 1)) begin
                  o_tx_valid <= 1'b0;
                  state      <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == ADDR && i_rx_valid)
         addr_q <= addr_t'(i_rx_byte);
      if (state == DATA_IN && i_rx_valid)
         word_q <= {i_rx_byte, word_q[DATA_WIDTH-1:8]}; // LSB byte first.
      else if (state == MEM_WAIT && i_grant && !is_write)
         word_q <= i_rd_data;
      else if (state == DATA_OUT && i_tx_accept)
         word_q <= word_q >> 8;
   end

   assign o_tx_byte   = word_q[7:0];
   assign o_req_write = is_write;
   assign o_req_addr  = addr_q;
   assign o_req_data  = word_q;

endmodule

// ==== source/mem_uart.sv ====
`timescale 1ns/1ps

module mem_uart import mul_pkg::*; #(
   parameter int DATA_WIDTH = 128,
   parameter int ADDR_WIDTH = 8,
   parameter int SAMPLE     = 1250
) (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic [DATA_WIDTH-1:0] i_data,
   input  logic [ADDR_WIDTH-1:0] i_addr,
   output logic [DATA_WIDTH-1:0] o_data,
   input  logic                  i_read_valid,
   output logic                  o_read_accept,
   input  logic                  i_write_valid,
   output logic                  o_write_accept,
   input  logic                  i_uart_rx,
   output logic                  o_uart_tx
);

   typedef logic [DATA_WIDTH-1:0] word_t;
   typedef logic [ADDR_WIDTH-1:0] addr_t;

   byte_t rx_byte;
   logic  rx_valid;
   byte_t tx_byte;
   logic  tx_valid;
   logic  tx_accept;
   logic  host_req;
   logic  host_write;
   addr_t host_addr;
   word_t host_wdata;
   logic  host_grant;
   word_t host_rdata;

   uart_rx #(.SAMPLE(SAMPLE)) uart_rx_i (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_rx    (i_uart_rx),
      .o_byte  (rx_byte),
      .o_valid (rx_valid)
   );

   uart_tx #(.SAMPLE(SAMPLE)) uart_tx_i (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_byte   (tx_byte),
      .i_valid  (tx_valid),
      .o_accept (tx_accept),
      .o_tx     (o_uart_tx)
   );

   host_cmd #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) host_cmd_i (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_rx_byte   (rx_byte),
      .i_rx_valid  (rx_valid),
      .o_tx_byte   (tx_byte),
      .o_tx_valid  (tx_valid),
      .i_tx_accept (tx_accept),
      .o_req       (host_req),
      .o_req_write (host_write),
      .o_req_addr  (host_addr),
      .o_req_data  (host_wdata),
      .i_grant     (host_grant),
      .i_rd_data   (host_rdata)
   );

   word_mem #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) word_mem_i (
      .i_clk               (i_clk),
      .i_nrst              (i_nrst),
      .i_host_req          (host_req),
      .i_host_write        (host_write),
      .i_host_addr         (host_addr),
      .i_host_data         (host_wdata),
      .o_host_grant        (host_grant),
      .o_host_data         (host_rdata),
      .i_core_read         (i_read_valid),
      .i_core_write        (i_write_valid),
      .i_core_addr         (i_addr),
      .i_core_data         (i_data),
      .o_core_read_accept  (o_read_accept),
      .o_core_write_accept (o_write_accept),
      .o_core_data         (o_data)
   );

endmodule

// ==== source/mul_pkg.sv ====
package mul_pkg;

   // One serial byte.
   typedef logic [7:0] byte_t;

   // Core loop, one word in flight.
   typedef enum logic [1:0] {
      SEQ_READ,
      SEQ_MUL,
      SEQ_WRITE
   } seq_state_e;

   // Host command decoder.
   typedef enum logic [2:0] {
      IDLE,
      ADDR,
      DATA_IN,
      MEM_WAIT,
      DATA_OUT
   } host_state_e;

   // Host command bytes.
   localparam byte_t CMD_WRITE = 8'h57; // 'W'
   localparam byte_t CMD_READ  = 8'h52; // 'R'

endpackage

// ==== source/multiply_mem_uart.sv ====
`timescale 1ns/1ps

module multiply_mem_uart import mul_pkg::*; #(
   parameter int DATA_WIDTH = 128,
   parameter int ADDR_WIDTH = 8,
   parameter int SAMPLE     = 1250
) (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_rx,
   output logic o_tx
);

   localparam int HALF = DATA_WIDTH / 2;

   typedef logic [DATA_WIDTH-1:0] word_t;
   typedef logic [ADDR_WIDTH-1:0] addr_t;

   seq_state_e            state;
   logic [ADDR_WIDTH-2:0] slot;  // Operand slot in the lower half.
   addr_t                 addr;
   word_t                 mem_to_mul;
   word_t                 mul_to_mem;
   logic                  read_valid;
   logic                  read_accept;
   logic                  mul_valid;
   logic                  mul_accept;
   logic                  write_valid;
   logic                  write_accept;

   assign read_valid  = (state == SEQ_READ);
   assign mul_valid   = (state == SEQ_MUL);
   assign write_valid = (state == SEQ_WRITE);

   // Product goes to the paired slot in the upper half.
   assign addr = {write_valid, slot};

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= SEQ_READ;
         slot  <= '0;
      end else begin
         case (state)
            SEQ_READ:  if (read_accept) state <= SEQ_MUL;
            SEQ_MUL:   if (mul_accept) state <= SEQ_WRITE;
            SEQ_WRITE: if (write_accept) begin
               state <= SEQ_READ;
               slot  <= slot + 1'b1; // Wraps over the lower half.
            end
            default:   state <= SEQ_READ;
         endcase
      end
   end

   mem_uart #(
      .DATA_WIDTH (DATA_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH),
      .SAMPLE     (SAMPLE)
   ) mem_uart_i (
      .i_clk          (i_clk),
      .i_nrst         (i_nrst),
      .i_data         (mul_to_mem),
      .i_addr         (addr),
      .o_data         (mem_to_mul),
      .i_read_valid   (read_valid),
      .o_read_accept  (read_accept),
      .i_write_valid  (write_valid),
      .o_write_accept (write_accept),
      .i_uart_rx      (i_rx),
      .o_uart_tx      (o_tx)
   );

   shift_add_multiplier #(
      .DATA_WIDTH_A (HALF),
      .DATA_WIDTH_B (HALF)
   ) shift_add_multiplier_i (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_a      (mem_to_mul[HALF-1:0]),
      .i_b      (mem_to_mul[DATA_WIDTH-1:HALF]),
      .o_c      (mul_to_mem),
      .i_valid  (mul_valid),
      .o_accept (mul_accept)
   );

endmodule

// ==== source/shift_add_multiplier.sv ====
`timescale 1ns/1ps

module shift_add_multiplier #(
   parameter int DATA_WIDTH_A = 64,
   parameter int DATA_WIDTH_B = 64
) (
   input  logic                               i_clk,
   input  logic                               i_nrst,
   input  logic [DATA_WIDTH_A-1:0]            i_a,
   input  logic [DATA_WIDTH_B-1:0]            i_b,
   output logic [DATA_WIDTH_A+DATA_WIDTH_B-1:0] o_c,
   input  logic                               i_valid,
   output logic                               o_accept
);

   localparam int PROD_W = DATA_WIDTH_A + DATA_WIDTH_B;
   localparam int CNT_W  = $clog2(DATA_WIDTH_B + 1);

   logic                    busy;
   logic                    start;
   logic [CNT_W-1:0]        cnt;
   logic [PROD_W-1:0]       mcand;
   logic [DATA_WIDTH_B-1:0] mplier;
   logic [PROD_W-1:0]       acc;

   assign start = i_valid && !busy && !o_accept;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy     <= 1'b0;
         cnt      <= '0;
         o_accept <= 1'b0;
      end else begin
         o_accept <= 1'b0;
         if (start) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(DATA_WIDTH_B);
         end else if (busy) begin
            cnt <= cnt - 1'b1;
            if (cnt == CNT_W'(1)) begin
               busy     <= 1'b0;
               o_accept <= 1'b1; // Last bit added this edge.
            end
         end
      end
   end

   // One multiplier bit per cycle.
   always_ff @(posedge i_clk) begin
      if (start) begin
         mcand  <= PROD_W'(i_a);
         mplier <= i_b;
         acc    <= '0;
      end else if (busy) begin
         if (mplier[0])
            acc <= acc + mcand;
         mcand  <= mcand << 1;
         mplier <= mplier >> 1;
      end
   end

   assign o_c = acc;

   a_a_held: assert property (@(posedge i_clk) disable iff (!i_nrst)
      busy |-> $stable(i_a));

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import mul_pkg::*; #(
   parameter int SAMPLE = 1250
) (
   input  logic  i_clk,
   input  logic  i_nrst,
   input  logic  i_rx,
   output byte_t o_byte,
   output logic  o_valid
);

   localparam int CNT_W = $clog2(SAMPLE);

   logic [1:0]       sync;
   logic             rx_prev;
   logic             busy;
   logic [CNT_W-1:0] cnt;
   logic [3:0]       bit_idx; // 0 start, 1..8 data, 9 stop.
   byte_t            shreg;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         sync    <= 2'b11;
         rx_prev <= 1'b1;
         busy    <= 1'b0;
         cnt     <= '0;
         bit_idx <= '0;
         o_valid <= 1'b0;
      end else begin
         sync    <= {sync[0], i_rx};
         rx_prev <= sync[1];
         o_valid <= 1'b0;
         if (!busy) begin
            if (rx_prev && !sync[1]) begin
               busy    <= 1'b1;
               cnt     <= CNT_W'(SAMPLE/2 - 1); // Land in the middle of the start bit.
               bit_idx <= '0;
            end
         end else if (cnt != 0) begin
            cnt <= cnt - 1'b1;
         end else begin
            cnt     <= CNT_W'(SAMPLE - 1);
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 4'd0 && sync[1])
               busy <= 1'b0; // Glitch, not a start bit.
            if (bit_idx == 4'd9) begin
               busy    <= 1'b0;
               o_valid <= sync[1]; // Bad stop bit drops the byte.
            end
         end
      end
   end

   // Data bits arrive LSB first.
   always_ff @(posedge i_clk) begin
      if (busy && cnt == 0 && bit_idx >= 4'd1 && bit_idx <= 4'd8)
         shreg <= {sync[1], shreg[7:1]};
   end

   assign o_byte = shreg;

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import mul_pkg::*; #(
   parameter int SAMPLE = 1250
) (
   input  logic  i_clk,
   input  logic  i_nrst,
   input  byte_t i_byte,
   input  logic  i_valid,
   output logic  o_accept,
   output logic  o_tx
);

   localparam int CNT_W = $clog2(SAMPLE);

   logic [9:0]       frame;
   logic [3:0]       bits_left;
   logic [CNT_W-1:0] cnt;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         frame     <= '1; // Line idles high.
         bits_left <= '0;
         cnt       <= '0;
         o_accept  <= 1'b0;
      end else begin
         o_accept <= 1'b0;
         if (bits_left == 0) begin
            if (i_valid) begin
               frame     <= {1'b1, i_byte, 1'b0};
               bits_left <= 4'd10;
               cnt       <= CNT_W'(SAMPLE - 1);
               o_accept  <= 1'b1;
            end
         end else if (cnt != 0) begin
            cnt <= cnt - 1'b1;
         end else begin
            frame     <= {1'b1, frame[9:1]};
            bits_left <= bits_left - 1'b1;
            cnt       <= CNT_W'(SAMPLE - 1);
         end
      end
   end

   assign o_tx = frame[0];

   // Sender must hold the byte until it is taken.
   a_byte_held: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_valid && !o_accept) |=> (i_valid && $stable(i_byte)));

endmodule

// ==== source/word_mem.sv ====
`timescale 1ns/1ps

module word_mem #(
   parameter int DATA_WIDTH = 128,
   parameter int ADDR_WIDTH = 8
) (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_host_req,
   input  logic                  i_host_write,
   input  logic [ADDR_WIDTH-1:0] i_host_addr,
   input  logic [DATA_WIDTH-1:0] i_host_data,
   output logic                  o_host_grant,
   output logic [DATA_WIDTH-1:0] o_host_data,
   input  logic                  i_core_read,
   input  logic                  i_core_write,
   input  logic [ADDR_WIDTH-1:0] i_core_addr,
   input  logic [DATA_WIDTH-1:0] i_core_data,
   output logic                  o_core_read_accept,
   output logic                  o_core_write_accept,
   output logic [DATA_WIDTH-1:0] o_core_data
);

   typedef logic [DATA_WIDTH-1:0] word_t;

   word_t mem [2**ADDR_WIDTH];

   logic host_go;
   logic core_wr_go;
   logic core_rd_go;

   // Host first. A request just served is not taken twice.
   assign host_go    = i_host_req && !o_host_grant;
   assign core_wr_go = !host_go && i_core_write && !o_core_write_accept;
   assign core_rd_go = !host_go && !core_wr_go && i_core_read && !o_core_read_accept;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_host_grant        <= 1'b0;
         o_core_read_accept  <= 1'b0;
         o_core_write_accept <= 1'b0;
      end else begin
         o_host_grant        <= host_go;
         o_core_read_accept  <= core_rd_go;
         o_core_write_accept <= core_wr_go;
      end
   end

   always_ff @(posedge i_clk) begin
      if (host_go) begin
         if (i_host_write)
            mem[i_host_addr] <= i_host_data;
         o_host_data <= mem[i_host_addr];
      end else if (core_wr_go) begin
         mem[i_core_addr] <= i_core_data;
      end else if (core_rd_go) begin
         o_core_data <= mem[i_core_addr];
      end
   end

endmodule
